// File: rtl/ifmap_config.svh
`ifndef IFMAP_CONFIG_SVH
`define IFMAP_CONFIG_SVH

// Word and address widths of the GLB bank
`define IFMAP_DATA_W      32
`define IFMAP_ADDR_W      10
`define IFMAP_GLB_DEPTH   1024

// Ifmap staging FIFO entries
`define IFMAP_FIFO_DEPTH  8

// Flow control on the two external streams
`define IFMAP_PE_CREDITS  4
`define IFMAP_CMD_DEPTH   2

// Task word count width
`define IFMAP_CNT_W       16

`endif

// File: rtl/ifmap_glb_pkg.sv
`include "ifmap_config.svh"

package ifmap_glb_pkg;

    // Load port write into the GLB bank
    typedef struct packed {
        logic                      valid;
        logic [`IFMAP_ADDR_W-1:0]  addr;
        logic [`IFMAP_DATA_W-1:0]  data;
    } glb_wr_t;

    // Ifmap read request toward the arbiter
    typedef struct packed {
        logic                      valid;
        logic [`IFMAP_ADDR_W-1:0]  addr;
    } glb_rd_req_t;

    // Read return, one cycle after the grant
    typedef struct packed {
        logic                      valid;
        logic [`IFMAP_DATA_W-1:0]  data;
    } glb_rd_rsp_t;

endpackage

// File: rtl/ifmap_stream_pkg.sv
`include "ifmap_config.svh"

package ifmap_stream_pkg;

    // Stream task from the L2 controller, count is at least 1
    typedef struct packed {
        logic                      valid;
        logic [`IFMAP_ADDR_W-1:0]  base;
        logic [`IFMAP_CNT_W-1:0]   count;
    } ifmap_task_t;

    // One word toward the PE array
    typedef struct packed {
        logic                      valid;
        logic [`IFMAP_DATA_W-1:0]  data;
        logic                      last;
    } pe_beat_t;

    // Refill/drain controller states
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_FILL  = 2'd1,
        CTRL_DRAIN = 2'd2
    } ctrl_state_e;

endpackage

// File: rtl/ifmap_task_intake.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_task_intake (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ifmap_stream_pkg::ifmap_task_t  cmd_i,
    input  logic                           task_take_i,
    output ifmap_stream_pkg::ifmap_task_t  task_o,
    output logic                           cmd_credit_o
);

    localparam int DEPTH = `IFMAP_CMD_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    ifmap_stream_pkg::ifmap_task_t q_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [OCC_W-1:0] occ_q;
    logic             enq;
    logic             deq;

    // Upstream only sends while holding a credit, so no full check
    assign enq = cmd_i.valid;
    assign deq = task_take_i && (occ_q != '0);

    always_ff @(posedge clk) begin
        if (enq) begin
            q_mem[wr_ptr_q] <= cmd_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            occ_q <= occ_q + OCC_W'(enq) - OCC_W'(deq);
        end
    end

    // Head entry, valid whenever the queue holds something
    assign task_o.valid = (occ_q != '0);
    assign task_o.base  = q_mem[rd_ptr_q].base;
    assign task_o.count = q_mem[rd_ptr_q].count;

    // One credit back per dequeued entry
    assign cmd_credit_o = deq;

endmodule

// File: rtl/ifmap_glb_port.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_glb_port (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ifmap_glb_pkg::glb_wr_t       glb_wr_i,
    input  ifmap_glb_pkg::glb_rd_req_t   rd_req_i,
    output logic                         rd_permit_o,
    output ifmap_glb_pkg::glb_rd_rsp_t   rd_rsp_o
);

    localparam int DEPTH = `IFMAP_GLB_DEPTH;

    logic [`IFMAP_DATA_W-1:0] mem [DEPTH];

    logic [`IFMAP_DATA_W-1:0] rd_data_q;
    logic                     rd_valid_q;

    // Fixed priority, the load port always wins the single port
    assign rd_permit_o = rd_req_i.valid && !glb_wr_i.valid;

    // Single-port array, one access per cycle
    always_ff @(posedge clk) begin
        if (glb_wr_i.valid) begin
            mem[glb_wr_i.addr] <= glb_wr_i.data;
        end else if (rd_req_i.valid) begin
            rd_data_q <= mem[rd_req_i.addr];
        end
    end

    // Return flag for a granted read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_permit_o;
        end
    end

    assign rd_rsp_o.valid = rd_valid_q;
    assign rd_rsp_o.data  = rd_data_q;

endmodule

// File: rtl/ifmap_fifo.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_fifo (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clr_i,
    input  logic                                  push_i,
    input  logic [`IFMAP_DATA_W-1:0]              push_data_i,
    input  logic                                  pop_i,
    output logic [`IFMAP_DATA_W-1:0]              pop_data_o,
    output logic                                  empty_o,
    output logic [$clog2(`IFMAP_FIFO_DEPTH+1)-1:0] count_o
);

    localparam int DEPTH = `IFMAP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int OCC_W = $clog2(DEPTH + 1);

    logic [`IFMAP_DATA_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [OCC_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_pop  = pop_i && (count_q != '0);
    assign do_push = push_i && ((count_q != OCC_W'(DEPTH)) || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // clr_i restarts the ring at the start of every task
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clr_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + OCC_W'(do_push) - OCC_W'(do_pop);
        end
    end

    // First word falls through
    assign pop_data_o = mem[rd_ptr_q];
    assign empty_o    = (count_q == '0);
    assign count_o    = count_q;

endmodule

// File: rtl/ifmap_fifo_ctrl.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_fifo_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  ifmap_stream_pkg::ifmap_task_t         task_i,
    output logic                                  task_take_o,
    output ifmap_glb_pkg::glb_rd_req_t            rd_req_o,
    input  logic                                  rd_permit_i,
    input  ifmap_glb_pkg::glb_rd_rsp_t            rd_rsp_i,
    output logic                                  fifo_push_o,
    output logic [`IFMAP_DATA_W-1:0]              fifo_push_data_o,
    output logic                                  fifo_clr_o,
    input  logic [$clog2(`IFMAP_FIFO_DEPTH+1)-1:0] fifo_count_i,
    input  logic                                  fifo_empty_i,
    input  logic                                  can_send_i,
    output logic                                  fifo_pop_o,
    output logic                                  pop_last_o
);

    localparam int CNT_W = `IFMAP_CNT_W;

    ifmap_stream_pkg::ctrl_state_e cs, ns;

    logic [`IFMAP_ADDR_W-1:0] base_q;
    logic [CNT_W-1:0]         count_q;
    logic [CNT_W-1:0]         req_ptr_q;
    logic [CNT_W-1:0]         pop_cnt_q;
    logic                     room;
    logic                     words_left;

    // Count the read that may still be in flight toward the FIFO
    assign room       = (32'(fifo_count_i) + 32'(rd_rsp_i.valid)) < `IFMAP_FIFO_DEPTH;
    assign words_left = (req_ptr_q != count_q);

    assign task_take_o = (cs == ifmap_stream_pkg::CTRL_IDLE) && task_i.valid;
    assign fifo_clr_o  = task_take_o;

    // Address stays at base + req_ptr until the arbiter permits it
    assign rd_req_o.valid = (cs == ifmap_stream_pkg::CTRL_FILL) && words_left && room;
    assign rd_req_o.addr  = base_q + req_ptr_q[`IFMAP_ADDR_W-1:0];

    assign fifo_push_o      = rd_rsp_i.valid;
    assign fifo_push_data_o = rd_rsp_i.data;

    assign fifo_pop_o = (cs == ifmap_stream_pkg::CTRL_DRAIN) && !fifo_empty_i && can_send_i;
    assign pop_last_o = fifo_pop_o && (pop_cnt_q == count_q - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs <= ifmap_stream_pkg::CTRL_IDLE;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        unique case (cs)
            ifmap_stream_pkg::CTRL_IDLE: begin
                if (task_i.valid) begin
                    ns = ifmap_stream_pkg::CTRL_FILL;
                end
            end
            ifmap_stream_pkg::CTRL_FILL: begin
                // FIFO would overflow or all words requested
                if (!rd_req_o.valid) begin
                    ns = ifmap_stream_pkg::CTRL_DRAIN;
                end
            end
            ifmap_stream_pkg::CTRL_DRAIN: begin
                if (pop_last_o) begin
                    ns = ifmap_stream_pkg::CTRL_IDLE;
                end else if (fifo_empty_i && words_left) begin
                    ns = ifmap_stream_pkg::CTRL_FILL;
                end
            end
            default: ns = ifmap_stream_pkg::CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q    <= '0;
            count_q   <= '0;
            req_ptr_q <= '0;
            pop_cnt_q <= '0;
        end else if (task_take_o) begin
            base_q    <= task_i.base;
            count_q   <= task_i.count;
            req_ptr_q <= '0;
            pop_cnt_q <= '0;
        end else begin
            if (rd_req_o.valid && rd_permit_i) begin
                req_ptr_q <= req_ptr_q + 1'b1;
            end
            if (fifo_pop_o) begin
                pop_cnt_q <= pop_cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: rtl/ifmap_pe_sender.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_pe_sender (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pop_i,
    input  logic [`IFMAP_DATA_W-1:0]    pop_data_i,
    input  logic                        pop_last_i,
    output logic                        can_send_o,
    output ifmap_stream_pkg::pe_beat_t  pe_beat_o,
    input  logic                        pe_credit_i
);

    localparam int CRD_W = $clog2(`IFMAP_PE_CREDITS + 1);

    logic [CRD_W-1:0]         credit_q;
    logic                     beat_valid_q;
    logic [`IFMAP_DATA_W-1:0] beat_data_q;
    logic                     beat_last_q;

    // The beat on the wire still owns a credit
    assign can_send_o = credit_q > CRD_W'(beat_valid_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid_q <= 1'b0;
            credit_q     <= CRD_W'(`IFMAP_PE_CREDITS);
        end else begin
            beat_valid_q <= pop_i;
            credit_q     <= credit_q - CRD_W'(beat_valid_q) + CRD_W'(pe_credit_i);
        end
    end

    always_ff @(posedge clk) begin
        if (pop_i) begin
            beat_data_q <= pop_data_i;
            beat_last_q <= pop_last_i;
        end
    end

    assign pe_beat_o.valid = beat_valid_q;
    assign pe_beat_o.data  = beat_data_q;
    assign pe_beat_o.last  = beat_last_q;

endmodule

// File: rtl/ifmap_buffer_top.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_buffer_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ifmap_stream_pkg::ifmap_task_t  cmd_i,
    output logic                           cmd_credit_o,
    input  ifmap_glb_pkg::glb_wr_t         glb_wr_i,
    output ifmap_stream_pkg::pe_beat_t     pe_beat_o,
    input  logic                           pe_credit_i
);

    localparam int FILL_W = $clog2(`IFMAP_FIFO_DEPTH + 1);

    ifmap_stream_pkg::ifmap_task_t task_s;
    ifmap_glb_pkg::glb_rd_req_t    rd_req;
    ifmap_glb_pkg::glb_rd_rsp_t    rd_rsp;

    logic                     task_take;
    logic                     rd_permit;
    logic                     fifo_push;
    logic [`IFMAP_DATA_W-1:0] fifo_push_data;
    logic                     fifo_clr;
    logic                     fifo_pop;
    logic [`IFMAP_DATA_W-1:0] fifo_pop_data;
    logic                     fifo_empty;
    logic [FILL_W-1:0]        fifo_count;
    logic                     can_send;
    logic                     pop_last;

    // Input side
    ifmap_task_intake u_task_intake (
        .clk(clk), .rst_n(rst_n), .cmd_i(cmd_i), .task_take_i(task_take),
        .task_o(task_s), .cmd_credit_o(cmd_credit_o)
    );

    // Processing part
    ifmap_glb_port u_glb_port (
        .clk(clk), .rst_n(rst_n), .glb_wr_i(glb_wr_i), .rd_req_i(rd_req),
        .rd_permit_o(rd_permit), .rd_rsp_o(rd_rsp)
    );

    ifmap_fifo u_fifo (
        .clk(clk), .rst_n(rst_n), .clr_i(fifo_clr), .push_i(fifo_push),
        .push_data_i(fifo_push_data), .pop_i(fifo_pop), .pop_data_o(fifo_pop_data),
        .empty_o(fifo_empty), .count_o(fifo_count)
    );

    ifmap_fifo_ctrl u_fifo_ctrl (
        .clk(clk), .rst_n(rst_n), .task_i(task_s), .task_take_o(task_take),
        .rd_req_o(rd_req), .rd_permit_i(rd_permit), .rd_rsp_i(rd_rsp),
        .fifo_push_o(fifo_push), .fifo_push_data_o(fifo_push_data),
        .fifo_clr_o(fifo_clr), .fifo_count_i(fifo_count), .fifo_empty_i(fifo_empty),
        .can_send_i(can_send), .fifo_pop_o(fifo_pop), .pop_last_o(pop_last)
    );

    // Output side
    ifmap_pe_sender u_pe_sender (
        .clk(clk), .rst_n(rst_n), .pop_i(fifo_pop), .pop_data_i(fifo_pop_data),
        .pop_last_i(pop_last), .can_send_o(can_send), .pe_beat_o(pe_beat_o),
        .pe_credit_i(pe_credit_i)
    );

endmodule

// File: bench/ifmap_buffer_sva.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_buffer_sva (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     fifo_push_i,
    input  logic [$clog2(`IFMAP_FIFO_DEPTH+1)-1:0]   fifo_count_i,
    input  logic                                     task_take_i,
    input  logic [`IFMAP_CNT_W-1:0]                  task_count_i,
    input  logic                                     beat_valid_i,
    input  logic [$clog2(`IFMAP_PE_CREDITS+1)-1:0]   credit_i
);

    int unsigned fail_cnt = 0;

    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_push_i |-> (fifo_count_i != `IFMAP_FIFO_DEPTH))
    else begin
        fail_cnt++;
        $error("FIFO push while the FIFO is full");
    end

    // The beat on the wire must still own a credit
    a_beat_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid_i |-> (credit_i != '0))
    else begin
        fail_cnt++;
        $error("PE beat sent with zero credits");
    end

    a_task_count_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        task_take_i |-> (task_count_i != '0))
    else begin
        fail_cnt++;
        $error("Task taken with a zero word count");
    end

endmodule

bind ifmap_fifo_ctrl ifmap_buffer_sva u_ctrl_sva (
    .clk(clk), .rst_n(rst_n), .fifo_push_i(fifo_push_o), .fifo_count_i(fifo_count_i),
    .task_take_i(task_take_o), .task_count_i(task_i.count),
    .beat_valid_i(1'b0), .credit_i('0)
);

bind ifmap_pe_sender ifmap_buffer_sva u_sender_sva (
    .clk(clk), .rst_n(rst_n), .fifo_push_i(1'b0), .fifo_count_i('0),
    .task_take_i(1'b0), .task_count_i('0),
    .beat_valid_i(pe_beat_o.valid), .credit_i(credit_q)
);

// File: bench/ifmap_buffer_tb.sv
`timescale 1ns/1ps
`include "ifmap_config.svh"

module ifmap_buffer_tb;

    localparam int CMD_DEPTH   = `IFMAP_CMD_DEPTH;
    localparam int PE_CREDITS  = `IFMAP_PE_CREDITS;
    // Words streamed over all tests: 3 + 20 + 5 + 6 + 16 + 16
    localparam int TOTAL_WORDS = 66;
    localparam int CYCLE_LIMIT = 2 * TOTAL_WORDS * `IFMAP_FIFO_DEPTH + 2000;

    logic                          clk;
    logic                          rst_n;
    logic                          cmd_credit_o;
    logic                          pe_credit_i;
    ifmap_stream_pkg::ifmap_task_t cmd_i;
    ifmap_glb_pkg::glb_wr_t        glb_wr_i;
    ifmap_stream_pkg::pe_beat_t    pe_beat_o;

    logic [`IFMAP_DATA_W-1:0] shadow_glb [`IFMAP_GLB_DEPTH];
    logic [`IFMAP_DATA_W-1:0] exp_data_q [$];
    logic                     exp_last_q [$];
    int unsigned              credit_due_q [$];
    int unsigned              cycle_cnt;
    int unsigned              last_due;
    int                       cmd_credits;
    int                       pe_held;
    int                       beat_cnt;
    int                       pulse_cnt;
    int                       errors;
    bit                       slow_credits;

    ifmap_buffer_top u_ifmap_buffer_top (
        .clk(clk), .rst_n(rst_n), .cmd_i(cmd_i), .cmd_credit_o(cmd_credit_o),
        .glb_wr_i(glb_wr_i), .pe_beat_o(pe_beat_o), .pe_credit_i(pe_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the PE stream never drained", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Fail t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : beat_monitor
        int unsigned due;
        if (rst_n && cmd_credit_o) begin
            cmd_credits++;
            pulse_cnt++;
        end
        if (rst_n && pe_beat_o.valid) begin
            beat_cnt++;
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Beat at %0t arrived with no word expected", $time);
            end else begin
                if (pe_beat_o.data !== exp_data_q[0])
                    report_mismatch("pe_beat_o.data", pe_beat_o.data, exp_data_q[0]);
                if (pe_beat_o.last !== exp_last_q[0])
                    report_mismatch("pe_beat_o.last", pe_beat_o.last, exp_last_q[0]);
                void'(exp_data_q.pop_front());
                void'(exp_last_q.pop_front());
            end
            if (pe_held == 0) begin
                errors++;
                $display("Beat at %0t was sent while the PE held no free credit", $time);
            end
            pe_held--;
            // PE hands the credit back 0 to 5 cycles later, one pulse per cycle
            due = cycle_cnt + 1 + (slow_credits ? 5 : $urandom % 6);
            last_due = (due > last_due) ? due : last_due + 1;
            credit_due_q.push_back(last_due);
        end
    end

    initial begin
        pe_credit_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            pe_credit_i = 1'b0;
            if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle_cnt) begin
                void'(credit_due_q.pop_front());
                pe_credit_i = 1'b1;
                pe_held++;
            end
        end
    end

    task automatic glb_write(input logic [9:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        glb_wr_i = {1'b1, addr, data};
        shadow_glb[addr] = data;
        @(posedge clk);
        #1;
        glb_wr_i.valid = 1'b0;
    endtask

    // Leaves valid high so a second call follows back to back
    task automatic send_cmd(input logic [9:0] base, input logic [15:0] count);
        int i;
        while (cmd_credits == 0) @(negedge clk);
        @(posedge clk);
        #1;
        cmd_i = {1'b1, base, count};
        cmd_credits--;
        for (i = 0; i < count; i++) begin
            exp_data_q.push_back(shadow_glb[base + 10'(i)]);
            exp_last_q.push_back(i == count - 1);
        end
    endtask

    task automatic cmd_idle;
        @(posedge clk);
        #1;
        cmd_i.valid = 1'b0;
    endtask

    task automatic wait_drained;
        @(posedge clk);
        while (exp_data_q.size() != 0 || pe_held != PE_CREDITS) @(posedge clk);
    endtask

    task automatic test_reset_quiet;
        repeat (10) begin
            @(negedge clk);
            if (cmd_credit_o !== 1'b0) report_mismatch("cmd_credit_o", cmd_credit_o, 0);
            if (pe_beat_o.valid !== 1'b0) report_mismatch("pe_beat_o.valid", pe_beat_o.valid, 0);
        end
    endtask

    // Up to two tasks, then the beat and credit pulse totals
    task automatic test_stream(input logic [9:0] base0, input logic [15:0] cnt0,
                               input logic [9:0] base1, input logic [15:0] cnt1);
        int beats0;
        int pulses0;
        beats0  = beat_cnt;
        pulses0 = pulse_cnt;
        send_cmd(base0, cnt0);
        if (cnt1 != 0) send_cmd(base1, cnt1);
        cmd_idle();
        wait_drained();
        if (beat_cnt - beats0 != cnt0 + cnt1)
            report_mismatch("beat count", beat_cnt - beats0, cnt0 + cnt1);
        if (pulse_cnt - pulses0 != ((cnt1 != 0) ? 2 : 1))
            report_mismatch("cmd_credit_o pulses", pulse_cnt - pulses0, (cnt1 != 0) ? 2 : 1);
        if (cmd_credits != CMD_DEPTH) report_mismatch("command credits", cmd_credits, CMD_DEPTH);
    endtask

    // Loads to 300..315 while the task reads 200..215
    task automatic test_load_during_stream;
        int n;
        fork
            test_stream(10'd200, 16'd16, 10'd0, 16'd0);
            for (n = 0; n < 20; n++) begin
                glb_write(10'd300 + 10'($urandom % 16), $urandom);
                repeat ($urandom % 3) @(posedge clk);
            end
        join
        test_stream(10'd300, 16'd16, 10'd0, 16'd0);
    endtask

    initial begin
        int          i;
        int unsigned sva_fails;
        void'($urandom(32'h312a9560));
        rst_n = 1'b0;
        cmd_i = '0;
        glb_wr_i = '0;
        cmd_credits = CMD_DEPTH;
        pe_held = PE_CREDITS;
        beat_cnt = 0;
        pulse_cnt = 0;
        errors = 0;
        last_due = 0;
        slow_credits = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_quiet();
        // Each preloaded word carries its own address
        for (i = 0; i < 320; i++) begin
            glb_write(10'(i), {6'h15, 10'(i), 6'h2a, ~10'(i)});
        end
        test_stream(10'd40, 16'd3, 10'd0, 16'd0);
        slow_credits = 1'b1;
        test_stream(10'd100, 16'd20, 10'd0, 16'd0);
        slow_credits = 1'b0;
        test_stream(10'd150, 16'd5, 10'd170, 16'd6);
        test_load_during_stream();
        repeat (5) @(posedge clk);
        sva_fails = u_ifmap_buffer_top.u_fifo_ctrl.u_ctrl_sva.fail_cnt
                  + u_ifmap_buffer_top.u_pe_sender.u_sender_sva.fail_cnt;
        $display("Beats %0d, check errors %0d, assertion failures %0d",
                 beat_cnt, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/ifmap_glb_pkg.sv
rtl/ifmap_stream_pkg.sv
rtl/ifmap_task_intake.sv
rtl/ifmap_glb_port.sv
rtl/ifmap_fifo.sv
rtl/ifmap_fifo_ctrl.sv
rtl/ifmap_pe_sender.sv
rtl/ifmap_buffer_top.sv
bench/ifmap_buffer_sva.sv
bench/ifmap_buffer_tb.sv
